// File: sources.f
isaPkg.sv
ctrlPkg.sv
handshakeSlot.sv
controlDecoder.sv
operandExtractor.sv
decodeBundler.sv
decodeStage.sv
decodeStage_checker.sv
decodeStage_tb.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, and grep the log for the result
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module decodeStage_tb -o VdecodeStage_tb
./obj_dir/VdecodeStage_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: decodeStage_tb.sv
// Testbench for the decode stage that drives seeded random fetch items and checks each bundle against a model
`timescale 1ns/10ps
`default_nettype none

module decodeStage_tb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int MIX_ITEMS      = 36;     // ALU I, ALU R, memory, branch, jump and LBI in turn
    localparam int PRESSURE_ITEMS = 10;     // Long ack delays
    localparam int TAIL_ITEMS     = 6;      // Before the halt word
    localparam int BLOCKED_ITEMS  = 3;      // Offered after halt
    localparam int BLOCK_WINDOW   = 25;     // Cycles each blocked item is offered
    localparam int PLANNED_ITEMS  = MIX_ITEMS + PRESSURE_ITEMS + TAIL_ITEMS + 1 + BLOCKED_ITEMS;
    localparam int CYCLE_LIMIT    = 40 * PLANNED_ITEMS + RESET_CYCLES;

    logic          clk;
    logic          rstN;
    logic          inReq;
    fetchItem_t    inItem;
    logic          inAck;
    logic          outReq;
    decodedInstr_t outBundle;
    logic          outAck;
    logic          halted;
    decodedInstr_t expectQ[$];              // Model results in send order
    int            sentCount;
    int            receivedCount;
    int            cycleCount;
    int unsigned   ackMin;                  // Consumer delay range in cycles
    int unsigned   ackMax;

    decodeStage i_decodeStage (
        .clk(clk), .rstN(rstN), .inReq(inReq), .inItem(inItem), .inAck(inAck),
        .outReq(outReq), .outBundle(outBundle), .outAck(outAck), .halted(halted)
    );

    always #5 clk = ~clk;                   // 10 ns period

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;                                 // Drive and sample 1 ns after the edge
    endtask

    task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s, expected %0h, got %0h", $time, what, expected, actual);
            abortRun();
        end
    endtask

    // Expected bundle from the instruction-set rules
    function automatic decodedInstr_t modelDecode(fetchItem_t item);
        word_t         w;
        opcode_t       op;
        decodedInstr_t b;
        w         = item.instr;
        op        = w[15:11];
        b         = '0;
        b.srcA    = w[10:8];
        b.srcB    = w[7:5];
        b.destReg = w[7:5];                 // I-format Rd unless changed below
        b.aluCtrl = op;
        b.aluSel  = 1'b1;
        b.imm     = {{11{w[4]}}, w[4:0]};
        case (op)
            5'b01000, 5'b01001, 5'b01010, 5'b01011,
            5'b10100, 5'b10101, 5'b10110, 5'b10111: begin
                b.regWrite = 1'b1;
                b.imm      = op[1] ? {11'b0, w[4:0]} : b.imm;    // Logic ops zero extend
            end
            5'b11001, 5'b11010, 5'b11011, 5'b11100, 5'b11101, 5'b11110, 5'b11111: begin
                b.regWrite = 1'b1;
                b.aluSel   = 1'b0;
                b.destReg  = w[4:2];
                b.imm      = {11'b0, w[4:0]};
            end
            OP_ST, OP_LD, OP_STU: begin
                b.memEnable = 1'b1;
                b.aluCtrl   = OP_ADDI;      // Base plus offset
                b.memWr     = (op != OP_LD);
                b.val2Reg   = (op == OP_LD);
                b.regWrite  = (op != OP_ST);
                b.destReg   = (op == OP_STU) ? w[10:8] : w[7:5];
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                b.aluSel  = 1'b0;
                b.destReg = w[10:8];
                b.imm     = {{8{w[7]}}, w[7:0]};
                b.pcSel   = (op == OP_BEQZ) ? item.rsZero : (op == OP_BNEZ) ? !item.rsZero :
                            (op == OP_BLTZ) ? item.rsSign : !item.rsSign;
            end
            OP_LBI, OP_SLBI: begin
                b.regWrite = 1'b1;
                b.destReg  = w[10:8];
                b.linkReg  = 2'b01;
                b.imm      = (op == OP_LBI) ? {{8{w[7]}}, w[7:0]} : {8'b0, w[7:0]};
            end
            OP_J, OP_JAL, OP_JR, OP_JALR: begin
                b.pcSel    = 1'b1;
                b.linkReg  = 2'b10;
                b.destReg  = 3'd7;
                b.aluCtrl  = OP_ADDI;
                b.regJmp   = (op == OP_JR) || (op == OP_JALR);
                b.regWrite = (op == OP_JAL) || (op == OP_JALR);
                b.imm      = b.regJmp ? {{8{w[7]}}, w[7:0]} : {{5{w[10]}}, w[10:0]};
            end
            OP_HALT: b.halt = 1'b1;
            default: b.halt = 1'b0;         // Not generated
        endcase
        return b;
    endfunction

    // Kind 0 ALU I, 1 ALU R, 2 memory, 3 branch, 4 jump or LBI, else halt
    function automatic fetchItem_t makeItem(int unsigned kind);
        logic [2:0] r;
        opcode_t    op;
        fetchItem_t item;
        r = 3'($urandom_range(7));
        case (kind)
            0: op = r[2] ? {3'b101, r[1:0]} : {3'b010, r[1:0]};
            1: op = 5'(25 + (r % 7));        // 11001 to 11111
            2: op = (r % 3 == 0) ? OP_ST : (r % 3 == 1) ? OP_LD : OP_STU;
            3: op = {3'b011, r[1:0]};
            4: op = (r % 6 == 0) ? OP_J : (r % 6 == 1) ? OP_JAL : (r % 6 == 2) ? OP_JR :
                    (r % 6 == 3) ? OP_JALR : (r % 6 == 4) ? OP_LBI : OP_SLBI;
            default: op = OP_HALT;
        endcase
        item.instr  = {op, 11'($urandom())};
        item.rsZero = 1'($urandom_range(1));
        item.rsSign = item.rsZero ? 1'b0 : 1'($urandom_range(1));   // Zero is not negative
        return item;
    endfunction

    task automatic sendItem(input fetchItem_t item);
        int unsigned gap;
        gap = $urandom_range(2);
        repeat (gap) tick();
        expectQ.push_back(modelDecode(item));
        sentCount = sentCount + 1;
        inItem    = item;
        inReq     = 1'b1;
        do tick(); while (!inAck);          // Slot captured
        inReq = 1'b0;
        do tick(); while (inAck);           // Return to zero
    endtask

    task automatic offerAfterHalt(input fetchItem_t item);
        inItem = item;
        inReq  = 1'b1;
        repeat (BLOCK_WINDOW) begin
            tick();
            if (inAck) begin
                $display("inAck went high for an item offered after the halt");
                abortRun();
            end
        end
        inReq = 1'b0;
        tick();
    endtask

    task automatic consume();
        decodedInstr_t got;
        decodedInstr_t exp;
        int unsigned   delay;
        forever begin
            tick();
            if (outReq) begin
                got = outBundle;
                if (expectQ.size() == 0) begin
                    $display("A bundle came out with no sent item left to match it");
                    abortRun();
                end
                exp = expectQ.pop_front();
                checkEqual(64'(got.destReg), 64'(exp.destReg), "destReg");
                checkEqual(64'(got.imm), 64'(exp.imm), "imm");
                checkEqual(64'(got.pcSel), 64'(exp.pcSel), "pcSel");
                checkEqual(64'(got), 64'(exp), "whole bundle");
                if (got.halt) begin
                    checkEqual(64'(halted), 64'(1), "halted with the halt bundle");
                end
                receivedCount = receivedCount + 1;
                delay         = $urandom_range(ackMax, ackMin);
                repeat (delay) tick();
                outAck = 1'b1;
                do tick(); while (outReq);
                outAck = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(67));                // Fixed seed for the whole run
        clk = 1'b0;
        rstN = 1'b0;
        inReq = 1'b0;
        inItem = '0;
        outAck = 1'b0;
        sentCount = 0;
        receivedCount = 0;
        cycleCount = 0;
        ackMin = 0;
        ackMax = 5;
        repeat (RESET_CYCLES) tick();
        checkEqual(64'({inAck, outReq, halted}), 64'(0), "handshake outputs in reset");
        rstN = 1'b1;
        fork
            consume();
        join_none
        for (int i = 0; i < MIX_ITEMS; i++) sendItem(makeItem(i % 5));
        ackMin = 6;                         // Back-pressure from execute
        ackMax = 15;
        for (int i = 0; i < PRESSURE_ITEMS; i++) sendItem(makeItem($urandom_range(4)));
        ackMin = 0;
        ackMax = 5;
        for (int i = 0; i < TAIL_ITEMS; i++) sendItem(makeItem(i % 5));
        sendItem(makeItem(5));              // Halt word
        while (receivedCount < sentCount) tick();
        checkEqual(64'(halted), 64'(1), "halted after the halt bundle");
        for (int i = 0; i < BLOCKED_ITEMS; i++) offerAfterHalt(makeItem(i % 5));
        if (expectQ.size() == 0 && receivedCount == sentCount && halted && !outReq) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Run ended with %0d of %0d items out", receivedCount, sentCount);
            abortRun();
        end
    end

endmodule

`default_nettype wire

// File: decodeStage_checker.sv
// Protocol and halt assertions bound into the decode stage top level
`timescale 1ns/10ps
`default_nettype none

module decodeStage_checker (
    input logic                   clk,
    input logic                   rstN,
    input logic                   inReq,
    input logic                   inAck,
    input logic                   outReq,
    input ctrlPkg::decodedInstr_t outBundle,
    input logic                   outAck,
    input logic                   halted
);
    outReqHold: assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> outReq)                    // No withdraw before ack
        else $error("outReq dropped before outAck");

    outBundleStable: assert property (@(posedge clk) disable iff (!rstN)
        outReq |=> $stable(outBundle))                   // Data held while offered
        else $error("outBundle changed while outReq was high");

    inAckCaused: assert property (@(posedge clk) disable iff (!rstN)
        $rose(inAck) |-> $past(inReq))
        else $error("inAck rose without a preceding inReq");

    noOutputAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        $past(halted) |-> !$rose(outReq))                // Halt bundle rises with halted
        else $error("outReq rose after halted was set");

endmodule

bind decodeStage decodeStage_checker protocolCheck (
    .clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck), .outReq(outReq),
    .outBundle(outBundle), .outAck(outAck), .halted(halted)
);

`default_nettype wire

// File: decodeStage.sv
// Decode stage top level joining the input slot, the parallel decoder and extractor, the bundler and the output slot
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   inReq,      // From fetch
    input  ctrlPkg::fetchItem_t    inItem,
    output logic                   inAck,
    output logic                   outReq,     // Toward execute
    output ctrlPkg::decodedInstr_t outBundle,
    input  logic                   outAck,
    output logic                   halted
);
    import isaPkg::*;
    import ctrlPkg::*;

    fetchItem_t     heldItem;                  // Item held by the input slot
    logic           midReq;                    // Input slot full
    logic           midAck;                    // Output slot upstream ack
    logic           inReqGated;
    logic           commit;
    ctrlWord_t      ctrl;
    operandFields_t fields;
    decodedInstr_t  bundle;

    assign inReqGated = inReq & ~halted;       // No intake after a halt
    // Same condition the output slot uses to capture
    assign commit = midReq & ~midAck & ~outReq & ~outAck;

    handshakeSlot #(.payload_t(fetchItem_t)) inSlot (
        .clk(clk), .rstN(rstN),
        .upReq(inReqGated), .upData(inItem), .upAck(inAck),
        .downReq(midReq), .downData(heldItem), .downAck(midAck)
    );

    controlDecoder decoder (
        .opcode(heldItem.instr[OPC_MSB:OPC_LSB]),
        .rsZero(heldItem.rsZero), .rsSign(heldItem.rsSign), .ctrl(ctrl)
    );

    operandExtractor extractor (.instr(heldItem.instr), .fields(fields));

    decodeBundler bundler (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .fields(fields),
        .commit(commit), .bundle(bundle), .halted(halted)
    );

    handshakeSlot #(.payload_t(decodedInstr_t)) outSlot (
        .clk(clk), .rstN(rstN),
        .upReq(midReq), .upData(bundle), .upAck(midAck),
        .downReq(outReq), .downData(outBundle), .downAck(outAck)
    );

endmodule

`default_nettype wire

// File: decodeBundler.sv
// Merges control word and operand fields into the execute bundle, and keeps the halted state
`timescale 1ns/10ps
`default_nettype none

module decodeBundler (
    input  logic                    clk,
    input  logic                    rstN,
    input  ctrlPkg::ctrlWord_t      ctrl,
    input  ctrlPkg::operandFields_t fields,
    input  logic                    commit,   // Output slot captures at this edge
    output ctrlPkg::decodedInstr_t  bundle,
    output logic                    halted    // Sticky until reset
);
    import isaPkg::*;

    always_comb begin
        bundle.regWrite  = ctrl.regWrite;     // Control passes straight on
        bundle.pcSel     = ctrl.pcSel;
        bundle.regJmp    = ctrl.regJmp;
        bundle.memEnable = ctrl.memEnable;
        bundle.memWr     = ctrl.memWr;
        bundle.aluCtrl   = ctrl.aluCtrl;
        bundle.val2Reg   = ctrl.val2Reg;
        bundle.aluSel    = ctrl.aluSel;
        bundle.halt      = ctrl.halt;
        bundle.linkReg   = ctrl.linkReg;
        bundle.siic      = ctrl.siic;
        bundle.srcA      = fields.rs;
        bundle.srcB      = fields.rt;

        case (ctrl.destSel)
            DEST_RS:  bundle.destReg = fields.rs;
            DEST_RDR: bundle.destReg = fields.rdR;
            DEST_R7:  bundle.destReg = REG_LINK;
            DEST_RDI: bundle.destReg = fields.rdI;
        endcase

        case (ctrl.immSel)
            IMM_ZEXT5:  bundle.imm = fields.zExt5;
            IMM_ZEXT8:  bundle.imm = fields.zExt8;
            IMM_ZEXT11: bundle.imm = fields.zExt11;
            IMM_SEXT8:  bundle.imm = fields.sExt8;
            IMM_SEXT11: bundle.imm = fields.sExt11;
            default:    bundle.imm = fields.sExt5;  // IMM_SEXT5 and spare codes
        endcase
    end

    // Set once a halt bundle is handed to the output slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (commit && ctrl.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: operandExtractor.sv
// Slices register indices and forms every extended immediate candidate of an instruction
`timescale 1ns/10ps
`default_nettype none

module operandExtractor (
    input  isaPkg::word_t           instr,      // Instruction word from the input slot
    output ctrlPkg::operandFields_t fields
);
    import isaPkg::*;

    localparam int PAD5  = WORD_W - IMM5_W;      // Fill widths for extension
    localparam int PAD8  = WORD_W - IMM8_W;
    localparam int PAD11 = WORD_W - IMM11_W;

    logic [IMM5_W-1:0]  imm5;
    logic [IMM8_W-1:0]  imm8;
    logic [IMM11_W-1:0] imm11;

    assign imm5  = instr[IMM5_W-1:0];            // Low bits of each format
    assign imm8  = instr[IMM8_W-1:0];
    assign imm11 = instr[IMM11_W-1:0];

    // Register fields whose meaning depends on the format
    assign fields.rs  = instr[RS_LSB  +: 3];
    assign fields.rt  = instr[RT_LSB  +: 3];
    assign fields.rdR = instr[RDR_LSB +: 3];
    assign fields.rdI = instr[RDI_LSB +: 3];     // Same bits as rt

    // Immediate candidates
    assign fields.sExt5  = {{PAD5{imm5[IMM5_W-1]}}, imm5};
    assign fields.zExt5  = {{PAD5{1'b0}}, imm5};
    assign fields.sExt8  = {{PAD8{imm8[IMM8_W-1]}}, imm8};
    assign fields.zExt8  = {{PAD8{1'b0}}, imm8};
    assign fields.sExt11 = {{PAD11{imm11[IMM11_W-1]}}, imm11};
    assign fields.zExt11 = {{PAD11{1'b0}}, imm11};

endmodule

`default_nettype wire

// File: controlDecoder.sv
// Opcode and Rs-flag table producing the control word of the decode stage
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
    input  isaPkg::opcode_t    opcode,          // Instruction bits 15 to 11
    input  logic               rsZero,          // Rs flag from fetch
    input  logic               rsSign,          // Rs flag from fetch
    output ctrlPkg::ctrlWord_t ctrl
);
    import isaPkg::*;

    always_comb begin
        // Defaults for every field, overridden per opcode below
        ctrl         = '0;                      // No writes, no memory, no jump
        ctrl.destSel = DEST_RDI;
        ctrl.aluSel  = 1'b1;                    // Immediate into the ALU
        ctrl.aluCtrl = opcode;                  // Most ops pass the opcode through
        ctrl.immSel  = IMM_SEXT5;
        ctrl.linkReg = LINK_NONE;

        casez (opcode)
            5'b000??: begin                     // HALT, NOP, SIIC, RTI
                ctrl.halt = (opcode == OP_HALT);  // Stops intake once committed
                ctrl.siic = (opcode == OP_SIIC);
                if (opcode == OP_RTI) begin
                    ctrl.aluCtrl = OP_NOP;      // RTI behaves as NOP here
                end
            end

            5'b010??, 5'b101??: begin           // I-format 1 ALU ops
                ctrl.regWrite = 1'b1;
                if (opcode[1]) begin
                    ctrl.immSel = IMM_ZEXT5;    // Logic ops zero extend
                end else begin
                    ctrl.immSel = IMM_SEXT5;    // Arithmetic sign extends
                end
            end

            5'b1000?: begin                     // ST and LD
                ctrl.memEnable = 1'b1;
                ctrl.aluCtrl   = OP_ADDI;       // Address = Rs + imm
                if (opcode == OP_LD) begin
                    ctrl.val2Reg  = 1'b1;       // Memory data to Rd
                    ctrl.regWrite = 1'b1;
                end else begin
                    ctrl.memWr    = 1'b1;       // Rd to memory
                end
            end

            OP_STU: begin                       // Store, then Rs updated with address
                ctrl.destSel   = DEST_RS;
                ctrl.aluCtrl   = OP_ADDI;
                ctrl.regWrite  = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.memEnable = 1'b1;
            end

            5'b11001, 5'b1101?, 5'b111??: begin // R-format codes apart from LBI at 11000
                ctrl.aluSel   = 1'b0;           // Rt into the ALU
                ctrl.destSel  = DEST_RDR;
                ctrl.immSel   = IMM_ZEXT5;      // Unused by R-format
                ctrl.regWrite = 1'b1;
            end

            5'b011??: begin                     // Conditional branches on Rs
                ctrl.aluSel  = 1'b0;
                ctrl.destSel = DEST_RS;         // Nothing written
                ctrl.immSel  = IMM_SEXT8;
                case (opcode)
                    OP_BEQZ: ctrl.pcSel = rsZero;
                    OP_BNEZ: ctrl.pcSel = ~rsZero;
                    OP_BLTZ: ctrl.pcSel = rsSign;
                    OP_BGEZ: ctrl.pcSel = ~rsSign;
                    default: ctrl.pcSel = 1'b0; // Not reached inside 011??
                endcase
            end

            OP_LBI, OP_SLBI: begin              // Load byte immediate into Rs
                ctrl.destSel  = DEST_RS;
                ctrl.regWrite = 1'b1;
                ctrl.linkReg  = LINK_LBI;
                if (opcode == OP_LBI) begin
                    ctrl.immSel = IMM_SEXT8;
                end else begin
                    ctrl.immSel = IMM_ZEXT8;    // SLBI ORs into Rs << 8
                end
            end

            5'b001??: begin                     // J, JR, JAL, JALR
                ctrl.pcSel    = 1'b1;
                ctrl.linkReg  = LINK_PC;
                ctrl.destSel  = DEST_R7;
                ctrl.aluCtrl  = OP_ADDI;
                ctrl.regJmp   = opcode[0];      // JR and JALR use Rs
                ctrl.regWrite = opcode[1];      // JAL and JALR link
                if (opcode[0]) begin
                    ctrl.immSel = IMM_SEXT8;
                end else begin
                    ctrl.immSel = IMM_SEXT11;   // J-format displacement
                end
            end

            default: begin
                ctrl.aluCtrl = opcode;          // All 32 codes matched above
            end
        endcase
    end

endmodule

`default_nettype wire

// File: handshakeSlot.sv
// One-entry register with four-phase req/ack on both sides and a payload type set by parameter
`timescale 1ns/10ps
`default_nettype none

module handshakeSlot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     upReq,       // Sender has stable data
    input  payload_t upData,
    output logic     upAck,       // High from capture until upReq drops
    output logic     downReq,     // High while full
    output payload_t downData,
    input  logic     downAck
);
    // State is held in the two handshake flags
    // upAck high means waiting for the sender to drop upReq
    // downReq high means full and waiting for the receiver's ack
    // Neither flag with downAck high means waiting for the receiver to drop ack
    // Neither flag with downAck low means empty
    logic     empty;
    logic     capture;
    payload_t heldData;

    assign empty   = !downReq && !downAck;        // Receiver finished its phase
    assign capture = empty && upReq && !upAck;    // Sender's phase also complete

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            upAck   <= 1'b0;
            downReq <= 1'b0;
        end else if (capture) begin
            upAck   <= 1'b1;                      // Both sides open at the same edge
            downReq <= 1'b1;
        end else begin
            if (upAck && !upReq) begin
                upAck <= 1'b0;                    // Upstream return to zero
            end
            if (downReq && downAck) begin
                downReq <= 1'b0;                  // Receiver took it
            end
        end
    end

    // Payload register held stable for the whole full period
    always_ff @(posedge clk) begin
        if (capture) begin
            heldData <= upData;
        end
    end

    assign downData = heldData;

endmodule

`default_nettype wire

// File: ctrlPkg.sv
// Bundle types passed between fetch, the decode sub-blocks and execute
`default_nettype none

package ctrlPkg;

    // One item from fetch, 18 bits
    typedef struct packed {
        isaPkg::word_t instr;          // Raw instruction word
        logic          rsZero;         // Rs == 0
        logic          rsSign;         // Rs < 0
    } fetchItem_t;

    typedef struct packed {
        logic               regWrite;  // Write the register file
        isaPkg::destSel_t   destSel;   // Which field names the destination
        logic               pcSel;     // PC + 2 + imm taken
        logic               regJmp;    // Jump target from Rs + imm
        logic               memEnable; // Data memory access
        logic               memWr;     // Data memory write
        isaPkg::opcode_t    aluCtrl;   // ALU operation, opcode encoded
        logic               val2Reg;   // Write back memory data, not ALU result
        logic               aluSel;    // ALU B input is the immediate
        isaPkg::immSel_t    immSel;    // Extension kind and size
        logic               halt;
        logic [1:0]         linkReg;   // {link, LBI}
        logic               siic;
    } ctrlWord_t;

    // Everything the word offers for the bundler to pick from
    typedef struct packed {
        isaPkg::regIdx_t rs;
        isaPkg::regIdx_t rt;
        isaPkg::regIdx_t rdR;
        isaPkg::regIdx_t rdI;
        isaPkg::word_t   sExt5;
        isaPkg::word_t   zExt5;
        isaPkg::word_t   sExt8;
        isaPkg::word_t   zExt8;
        isaPkg::word_t   sExt11;
        isaPkg::word_t   zExt11;
    } operandFields_t;

    typedef struct packed {
        logic            regWrite;
        logic            pcSel;
        logic            regJmp;
        logic            memEnable;
        logic            memWr;
        isaPkg::opcode_t aluCtrl;
        logic            val2Reg;
        logic            aluSel;
        logic            halt;
        logic [1:0]      linkReg;
        logic            siic;
        isaPkg::regIdx_t destReg;      // Final write register
        isaPkg::regIdx_t srcA;         // Rs
        isaPkg::regIdx_t srcB;         // Rt
        isaPkg::word_t   imm;          // Selected extended immediate
    } decodedInstr_t;

endpackage

`default_nettype wire

// File: isaPkg.sv
// Instruction-set opcodes, field positions and select codes, imported by the decode stage and its testbench
`default_nettype none

package isaPkg;

    localparam int WORD_W  = 16;              // Datapath and instruction width
    localparam int IMM5_W  = 5;               // I-format 1 immediate
    localparam int IMM8_W  = 8;               // I-format 2 immediate
    localparam int IMM11_W = 11;              // J-format displacement

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        opcode_t;      // Instruction bits 15 to 11
    typedef logic [2:0]        regIdx_t;      // Eight registers
    typedef logic [2:0]        immSel_t;      // {signExt, size} with size 00 for 5, 01 for 8, 10 for 11
    typedef logic [1:0]        destSel_t;

    // Field positions inside the instruction word
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 11;
    localparam int RS_LSB  = 8;               // Bits 10 to 8
    localparam int RT_LSB  = 5;               // Bits 7 to 5
    localparam int RDR_LSB = 2;               // R-format destination in bits 4 to 2
    localparam int RDI_LSB = 5;               // I-format destination in bits 7 to 5

    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP  = 5'b00001;
    localparam opcode_t OP_SIIC = 5'b00010;
    localparam opcode_t OP_RTI  = 5'b00011;
    localparam opcode_t OP_J    = 5'b00100;
    localparam opcode_t OP_JR   = 5'b00101;
    localparam opcode_t OP_JAL  = 5'b00110;
    localparam opcode_t OP_JALR = 5'b00111;
    localparam opcode_t OP_ADDI = 5'b01000;   // Also the ALU op of memory and jump instructions
    localparam opcode_t OP_BEQZ = 5'b01100;
    localparam opcode_t OP_BNEZ = 5'b01101;
    localparam opcode_t OP_BLTZ = 5'b01110;
    localparam opcode_t OP_BGEZ = 5'b01111;
    localparam opcode_t OP_ST   = 5'b10000;
    localparam opcode_t OP_LD   = 5'b10001;
    localparam opcode_t OP_SLBI = 5'b10010;
    localparam opcode_t OP_STU  = 5'b10011;
    localparam opcode_t OP_LBI  = 5'b11000;

    localparam immSel_t IMM_ZEXT5  = 3'b000;
    localparam immSel_t IMM_ZEXT8  = 3'b001;
    localparam immSel_t IMM_ZEXT11 = 3'b010;
    localparam immSel_t IMM_SEXT5  = 3'b100;
    localparam immSel_t IMM_SEXT8  = 3'b101;
    localparam immSel_t IMM_SEXT11 = 3'b110;

    localparam destSel_t DEST_RS  = 2'b00;
    localparam destSel_t DEST_RDR = 2'b01;
    localparam destSel_t DEST_R7  = 2'b10;
    localparam destSel_t DEST_RDI = 2'b11;

    localparam logic [1:0] LINK_NONE = 2'b00;
    localparam logic [1:0] LINK_LBI  = 2'b01;   // LBI and SLBI
    localparam logic [1:0] LINK_PC   = 2'b10;   // Jumps write PC + 2 to R7
    localparam regIdx_t    REG_LINK  = 3'd7;    // Link register

endpackage

`default_nettype wire
